/* filelist.f */
source/pipe_pkg.sv
source/hazard_if.sv
source/pipe_reg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_stage.sv
source/hazard_unit.sv
source/pipe_core.sv
test/tb_pipe_core.sv

/* run.sh */
#!/bin/sh
# Compile and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_pipe_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_pipe_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

/* source/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  pipe_pkg::if_id_t              i_if_id,
	input  logic                          i_wb_en,
	input  logic [pipe_pkg::REG_AW-1:0]   i_wb_reg,
	input  logic [pipe_pkg::XLEN-1:0]     i_wb_data,
	hazard_if.pipe                        hz,
	output pipe_pkg::id_ex_t              o_id_ex
);

	logic [pipe_pkg::XLEN-1:0]   regs [2**pipe_pkg::REG_AW];
	logic [5:0]                  opcode;
	logic [5:0]                  funct;
	logic [pipe_pkg::REG_AW-1:0] rs;
	logic [pipe_pkg::REG_AW-1:0] rt;
	logic [pipe_pkg::REG_AW-1:0] rd;
	logic [pipe_pkg::REG_AW-1:0] dst;
	logic                        use_rs;	// rs is a real source operand
	logic                        use_rt;
	pipe_pkg::wb_ctl_t           wb_ctl;
	pipe_pkg::mem_ctl_t          mem_ctl;
	pipe_pkg::ex_ctl_t           ex_ctl;

	assign opcode = i_if_id.instr[31:26];
	assign rs     = i_if_id.instr[25:21];
	assign rt     = i_if_id.instr[20:16];
	assign rd     = i_if_id.instr[15:11];
	assign funct  = i_if_id.instr[5:0];

	////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 2**pipe_pkg::REG_AW; i++)
				regs[i] <= '0;
		end else if (i_wb_en && i_wb_reg != '0) begin
			regs[i_wb_reg] <= i_wb_data;	// r0 stays zero
		end
	end

	// Write-through read so WB and ID can share a cycle
	function automatic logic [pipe_pkg::XLEN-1:0] rf_read(
		input logic [pipe_pkg::REG_AW-1:0] addr
	);
		if (addr == '0)
			return '0;
		if (i_wb_en && i_wb_reg == addr)
			return i_wb_data;
		return regs[addr];
	endfunction

	////////////////////////////////////////////////////////////
	// Control decoder
	////////////////////////////////////////////////////////////
	always_comb begin
		wb_ctl  = '0;
		mem_ctl = '0;
		ex_ctl  = '0;
		dst     = rt;	// I-type writes rt
		use_rs  = 1'b1;
		use_rt  = 1'b0;
		case (opcode)
			pipe_pkg::OP_RTYPE: begin
				dst              = rd;
				use_rt           = 1'b1;
				wb_ctl.reg_write = 1'b1;
				case (funct)
					pipe_pkg::FN_ADD: ex_ctl.alu_op = pipe_pkg::ALU_ADD;
					pipe_pkg::FN_SUB: ex_ctl.alu_op = pipe_pkg::ALU_SUB;
					pipe_pkg::FN_AND: ex_ctl.alu_op = pipe_pkg::ALU_AND;
					pipe_pkg::FN_OR:  ex_ctl.alu_op = pipe_pkg::ALU_OR;
					pipe_pkg::FN_SLT: ex_ctl.alu_op = pipe_pkg::ALU_SLT;
					default: begin	// Unknown funct runs as no-op
						wb_ctl.reg_write = 1'b0;
						use_rs           = 1'b0;
						use_rt           = 1'b0;
					end
				endcase
			end
			pipe_pkg::OP_ADDI: begin
				wb_ctl.reg_write = 1'b1;
				ex_ctl.alu_src   = 1'b1;
			end
			pipe_pkg::OP_LW: begin
				wb_ctl.reg_write  = 1'b1;
				wb_ctl.mem_to_reg = 1'b1;
				mem_ctl.mem_read  = 1'b1;
				ex_ctl.alu_src    = 1'b1;	// Base plus offset
			end
			pipe_pkg::OP_SW: begin
				mem_ctl.mem_write = 1'b1;
				ex_ctl.alu_src    = 1'b1;
				use_rt            = 1'b1;	// Store data
			end
			pipe_pkg::OP_BEQ: begin
				mem_ctl.branch = 1'b1;
				ex_ctl.alu_op  = pipe_pkg::ALU_SUB;
				use_rt         = 1'b1;
			end
			default: use_rs = 1'b0;	// No-op
		endcase
	end

	// Sources for load-use detection
	assign hz.id_rs = use_rs ? rs : '0;
	assign hz.id_rt = use_rt ? rt : '0;

	always_comb begin
		o_id_ex.pc4 = i_if_id.pc4;
		o_id_ex.rd1 = rf_read(rs);
		o_id_ex.rd2 = rf_read(rt);
		o_id_ex.imm = {{(pipe_pkg::XLEN-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};
		o_id_ex.rs  = rs;
		o_id_ex.rt  = rt;
		o_id_ex.rd  = dst;
		o_id_ex.wb  = wb_ctl;
		o_id_ex.mem = mem_ctl;
		o_id_ex.ex  = ex_ctl;
	end

	a_r0_zero : assert property (
		@(posedge i_clk) disable iff (!i_rst_n) regs[0] == '0
	) else $error("r0 became nonzero");

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input  pipe_pkg::id_ex_t                i_id_ex,
	input  pipe_pkg::ex_mem_t               i_ex_mem,
	input  pipe_pkg::mem_wb_t               i_mem_wb,
	hazard_if.pipe                          hz,
	output logic [pipe_pkg::XLEN-1:0]       o_branch_target,
	output pipe_pkg::ex_mem_t               o_ex_mem
);

	logic [pipe_pkg::XLEN-1:0] wb_val;	// Value MEM/WB is writing back
	logic [pipe_pkg::XLEN-1:0] op_a;
	logic [pipe_pkg::XLEN-1:0] rt_val;	// Forwarded rt and store data
	logic [pipe_pkg::XLEN-1:0] op_b;
	logic [pipe_pkg::XLEN-1:0] alu_res;

	assign wb_val = i_mem_wb.wb.mem_to_reg ? i_mem_wb.load_data : i_mem_wb.alu_res;

	////////////////////////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////////////////////////
	// Youngest producer first
	function automatic logic [pipe_pkg::XLEN-1:0] fwd(
		input logic [pipe_pkg::REG_AW-1:0] src,
		input logic [pipe_pkg::XLEN-1:0]   rf_val
	);
		if (i_ex_mem.wb.reg_write && i_ex_mem.dst != '0 && i_ex_mem.dst == src)
			return i_ex_mem.alu_res;
		if (i_mem_wb.wb.reg_write && i_mem_wb.dst != '0 && i_mem_wb.dst == src)
			return wb_val;
		return rf_val;
	endfunction

	always_comb begin
		op_a   = fwd(i_id_ex.rs, i_id_ex.rd1);
		rt_val = fwd(i_id_ex.rt, i_id_ex.rd2);
		op_b   = i_id_ex.ex.alu_src ? i_id_ex.imm : rt_val;
	end

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (i_id_ex.ex.alu_op)
			pipe_pkg::ALU_ADD: alu_res = op_a + op_b;
			pipe_pkg::ALU_SUB: alu_res = op_a - op_b;
			pipe_pkg::ALU_AND: alu_res = op_a & op_b;
			pipe_pkg::ALU_OR:  alu_res = op_a | op_b;
			pipe_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			default:           alu_res = '0;
		endcase
	end

	// beq resolves here
	assign hz.branch_taken = i_id_ex.mem.branch && (op_a == rt_val);
	assign o_branch_target = i_id_ex.pc4 + {i_id_ex.imm[pipe_pkg::XLEN-3:0], 2'b00};

	// Load in EX for load-use check
	assign hz.ex_rt       = i_id_ex.rt;
	assign hz.ex_mem_read = i_id_ex.mem.mem_read;

	always_comb begin
		o_ex_mem.alu_res    = alu_res;
		o_ex_mem.store_data = rt_val;
		o_ex_mem.dst        = i_id_ex.rd;
		o_ex_mem.wb         = i_id_ex.wb;
		o_ex_mem.mem        = i_id_ex.mem;
	end

endmodule

`default_nettype wire

/* source/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	hazard_if.fetch                     hz,
	input  logic [pipe_pkg::XLEN-1:0]   i_branch_target,
	input  logic [pipe_pkg::XLEN-1:0]   i_imem_data,
	output logic [pipe_pkg::XLEN-1:0]   o_imem_addr,
	output pipe_pkg::if_id_t            o_if_id
);

	logic [pipe_pkg::XLEN-1:0] pc;
	logic [pipe_pkg::XLEN-1:0] pc_plus4;

	assign pc_plus4 = pc + 32'd4;

	// Program counter
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pc <= '0;
		end else if (hz.branch_taken) begin
			pc <= i_branch_target;	// Redirect wins over stall
		end else if (!hz.stall) begin
			pc <= pc_plus4;
		end
	end

	assign o_imem_addr = pc;	// Instruction port answers same cycle

	always_comb begin
		o_if_id.instr = i_imem_data;
		o_if_id.pc4   = pc_plus4;
	end

endmodule

`default_nettype wire

/* source/hazard_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface hazard_if (
	input logic i_clk,
	input logic i_rst_n
);
	logic [pipe_pkg::REG_AW-1:0] id_rs;	// Zero when rs is not a source
	logic [pipe_pkg::REG_AW-1:0] id_rt;	// Zero when rt is not a source
	logic [pipe_pkg::REG_AW-1:0] ex_rt;
	logic                        ex_mem_read;	// Load sitting in EX
	logic                        branch_taken;
	logic                        stall;	// Hold PC and IF/ID
	logic                        flush_if_id;
	logic                        clear_id_ex;	// Bubble into EX

	// Detection logic
	modport unit (
		input  i_clk, i_rst_n, id_rs, id_rt, ex_rt, ex_mem_read, branch_taken,
		output stall, flush_if_id, clear_id_ex
	);

	modport fetch (input stall, branch_taken);

	// Decode and execute each drive their own half
	modport pipe (output id_rs, id_rt, ex_rt, ex_mem_read, branch_taken);

endinterface

`default_nettype wire

/* source/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	hazard_if.unit hz
);

	logic load_use;

	// Load in EX whose result ID needs next cycle
	assign load_use = hz.ex_mem_read && (hz.ex_rt != '0)
		&& ((hz.ex_rt == hz.id_rs) || (hz.ex_rt == hz.id_rt));

	assign hz.stall       = load_use;
	assign hz.flush_if_id = hz.branch_taken;	// Kill the instruction in ID
	assign hz.clear_id_ex = load_use || hz.branch_taken;

	// beq never reads memory so these cannot meet
	a_flush_no_hold : assert property (
		@(posedge hz.i_clk) disable iff (!hz.i_rst_n)
		hz.flush_if_id |-> !hz.stall
	) else $error("Flush of IF/ID while it is held");

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  pipe_pkg::ex_mem_t   i_ex_mem,
	output pipe_pkg::mem_wb_t   o_mem_wb
);

	logic [pipe_pkg::XLEN-1:0]    dmem [pipe_pkg::DMEM_WORDS];
	logic [pipe_pkg::DMEM_AW-1:0] idx;	// Word index

	assign idx = i_ex_mem.alu_res[pipe_pkg::DMEM_AW+1:2];

	// Store on the edge
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (i_ex_mem.mem.mem_write) begin
			dmem[idx] <= i_ex_mem.store_data;
		end
	end

	always_comb begin
		o_mem_wb.alu_res   = i_ex_mem.alu_res;
		o_mem_wb.load_data = i_ex_mem.mem.mem_read ? dmem[idx] : '0;	// Async read
		o_mem_wb.dst       = i_ex_mem.dst;
		o_mem_wb.wb        = i_ex_mem.wb;
	end

	a_rw_excl : assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!(i_ex_mem.mem.mem_read && i_ex_mem.mem.mem_write)
	) else $error("Load and store in the same instruction");

endmodule

`default_nettype wire

/* source/pipe_core.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_core (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	output logic [pipe_pkg::XLEN-1:0]     o_imem_addr,
	input  logic [pipe_pkg::XLEN-1:0]     i_imem_data,
	output logic                          o_stall,
	output logic                          o_wb_en,
	output logic [pipe_pkg::REG_AW-1:0]   o_wb_reg,
	output logic [pipe_pkg::XLEN-1:0]     o_wb_data
);

	pipe_pkg::if_id_t          if_id_d;
	pipe_pkg::if_id_t          if_id_q;
	pipe_pkg::id_ex_t          id_ex_d;
	pipe_pkg::id_ex_t          id_ex_q;
	pipe_pkg::ex_mem_t         ex_mem_d;
	pipe_pkg::ex_mem_t         ex_mem_q;
	pipe_pkg::mem_wb_t         mem_wb_d;
	pipe_pkg::mem_wb_t         mem_wb_q;
	logic [pipe_pkg::XLEN-1:0] branch_target;
	logic                      wb_en;
	logic [pipe_pkg::XLEN-1:0] wb_data;

	hazard_if hz (.i_clk(i_clk), .i_rst_n(i_rst_n));

	hazard_unit u_hazard (.hz(hz));

	////////////////////////////////////////////////////////////
	// IF
	////////////////////////////////////////////////////////////
	fetch_stage u_fetch (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.hz              (hz),
		.i_branch_target (branch_target),
		.i_imem_data     (i_imem_data),
		.o_imem_addr     (o_imem_addr),
		.o_if_id         (if_id_d)
	);

	pipe_reg #(.T(pipe_pkg::if_id_t)) u_if_id (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_hold  (hz.stall),
		.i_clear (hz.flush_if_id),
		.i_d     (if_id_d),
		.o_q     (if_id_q)
	);

	////////////////////////////////////////////////////////////
	// ID
	////////////////////////////////////////////////////////////
	decode_stage u_decode (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_if_id   (if_id_q),
		.i_wb_en   (wb_en),
		.i_wb_reg  (mem_wb_q.dst),
		.i_wb_data (wb_data),
		.hz        (hz),
		.o_id_ex   (id_ex_d)
	);

	pipe_reg #(.T(pipe_pkg::id_ex_t)) u_id_ex (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_hold  (1'b0),
		.i_clear (hz.clear_id_ex),	// Bubble on stall or flush
		.i_d     (id_ex_d),
		.o_q     (id_ex_q)
	);

	////////////////////////////////////////////////////////////
	// EX and MEM
	////////////////////////////////////////////////////////////
	execute_stage u_execute (
		.i_id_ex         (id_ex_q),
		.i_ex_mem        (ex_mem_q),
		.i_mem_wb        (mem_wb_q),
		.hz              (hz),
		.o_branch_target (branch_target),
		.o_ex_mem        (ex_mem_d)
	);

	pipe_reg #(.T(pipe_pkg::ex_mem_t)) u_ex_mem (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_hold  (1'b0),
		.i_clear (1'b0),
		.i_d     (ex_mem_d),
		.o_q     (ex_mem_q)
	);

	mem_stage u_mem (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_ex_mem (ex_mem_q),
		.o_mem_wb (mem_wb_d)
	);

	pipe_reg #(.T(pipe_pkg::mem_wb_t)) u_mem_wb (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_hold  (1'b0),
		.i_clear (1'b0),
		.i_d     (mem_wb_d),
		.o_q     (mem_wb_q)
	);

	// Writeback select
	assign wb_en   = mem_wb_q.wb.reg_write && (mem_wb_q.dst != '0);
	assign wb_data = mem_wb_q.wb.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_res;

	assign o_stall   = hz.stall;
	assign o_wb_en   = wb_en;
	assign o_wb_reg  = mem_wb_q.dst;
	assign o_wb_data = wb_data;

endmodule

`default_nettype wire

/* source/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////
	localparam int XLEN       = 32;	// Data and address width
	localparam int REG_AW     = 5;	// 32 architectural registers
	localparam int DMEM_WORDS = 16;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);	// Word index bits

	// Opcodes in instr[31:26]
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2B;
	localparam logic [5:0] OP_BEQ   = 6'h04;

	// R-type function codes in instr[5:0]
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2A;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,	// Zero so a bubble decodes as add
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4	// Signed compare
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// Control groups
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic reg_write;	// Result goes to register file
		logic mem_to_reg;	// Write back load data
	} wb_ctl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic branch;	// beq in flight
	} mem_ctl_t;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src;	// Operand B from immediate
	} ex_ctl_t;

	////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [XLEN-1:0] instr;
		logic [XLEN-1:0] pc4;
	} if_id_t;

	typedef struct packed {
		logic [XLEN-1:0]   pc4;
		logic [XLEN-1:0]   rd1;
		logic [XLEN-1:0]   rd2;
		logic [XLEN-1:0]   imm;	// Sign extended
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;	// Destination after decode
		wb_ctl_t           wb;
		mem_ctl_t          mem;
		ex_ctl_t           ex;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0]   alu_res;	// Also the memory address
		logic [XLEN-1:0]   store_data;
		logic [REG_AW-1:0] dst;
		wb_ctl_t           wb;
		mem_ctl_t          mem;
	} ex_mem_t;

	typedef struct packed {
		logic [XLEN-1:0]   alu_res;
		logic [XLEN-1:0]   load_data;
		logic [REG_AW-1:0] dst;
		wb_ctl_t           wb;
	} mem_wb_t;

endpackage

`default_nettype wire

/* source/pipe_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
	parameter type T = logic
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_hold,	// Keep current contents
	input  logic i_clear,	// Load a no-op and beat i_hold
	input  T     i_d,
	output T     o_q
);

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_q <= '0;	// All-zero payload is a no-op
		end else if (i_clear) begin
			o_q <= '0;
		end else if (!i_hold) begin
			o_q <= i_d;
		end
	end

	// A held stage shows the same payload one cycle on
	a_hold_stable : assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_hold && !i_clear) |=> $stable(o_q)
	) else $error("pipe_reg changed while held");

endmodule

`default_nettype wire

/* test/tb_pipe_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_core;

	logic        i_clk;
	logic        i_rst_n;
	logic [31:0] o_imem_addr;
	logic [31:0] i_imem_data;
	logic        o_stall;
	logic        o_wb_en;
	logic [4:0]  o_wb_reg;
	logic [31:0] o_wb_data;

	logic [31:0] prog [256];	// Instruction memory where zero words are no-ops
	int          prog_len;
	integer      seed;
	string       cur_test;
	int          test_errs;
	int          total_errs;
	int          tests_run;
	int          tests_failed;
	int          stall_cycles;
	logic [4:0]  exp_reg [$];	// Model writeback list
	logic [31:0] exp_data [$];
	logic [4:0]  got_reg [$];	// Observed writebacks
	logic [31:0] got_data [$];
	logic [31:0] addr_seq [$];	// Distinct fetch addresses in order

	pipe_core i_pipe_core (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.o_imem_addr (o_imem_addr),
		.i_imem_data (i_imem_data),
		.o_stall     (o_stall),
		.o_wb_en     (o_wb_en),
		.o_wb_reg    (o_wb_reg),
		.o_wb_data   (o_wb_data)
	);

	always #5 i_clk = ~i_clk;

	// Same-cycle instruction port
	assign i_imem_data = (o_imem_addr < 32'd1024) ? prog[o_imem_addr[9:2]] : '0;

	////////////////////////////////////////////////////////////
	// Encoding and stimulus helpers
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] r_type(input logic [5:0] fn,
		input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		return {pipe_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op,
		input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic add_word(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_errs = 0;
		prog_len  = 0;
		for (int i = 0; i < 256; i++)
			prog[i] = '0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			$display("test %s: %0d error(s)", cur_test, test_errs);
			tests_failed++;
			total_errs += test_errs;
		end
	endtask

	// Reset held for three cycles and released on a falling edge
	task automatic apply_reset();
		@(negedge i_clk);
		i_rst_n = 1'b0;
		repeat (3) @(negedge i_clk);
		i_rst_n = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// In-order ISA model
	////////////////////////////////////////////////////////////
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] mem [pipe_pkg::DMEM_WORDS];
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] wr_val;
		logic [4:0]  wr_reg;
		logic        wr;
		int          steps;
		exp_reg.delete();
		exp_data.delete();
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++)
			mem[i] = '0;
		pc    = '0;
		steps = 0;
		while (pc < 32'(prog_len * 4) && steps < 4096) begin
			w      = prog[pc[9:2]];
			a      = regs[w[25:21]];
			b      = regs[w[20:16]];
			imm    = {{16{w[15]}}, w[15:0]};
			addr   = a + imm;
			wr     = 1'b0;
			wr_reg = w[20:16];	// I-type destination
			wr_val = '0;
			pc     = pc + 32'd4;
			case (w[31:26])
				pipe_pkg::OP_RTYPE: begin
					wr     = 1'b1;
					wr_reg = w[15:11];
					case (w[5:0])
						pipe_pkg::FN_ADD: wr_val = a + b;
						pipe_pkg::FN_SUB: wr_val = a - b;
						pipe_pkg::FN_AND: wr_val = a & b;
						pipe_pkg::FN_OR:  wr_val = a | b;
						pipe_pkg::FN_SLT: wr_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default:          wr = 1'b0;	// Unknown funct
					endcase
				end
				pipe_pkg::OP_ADDI: begin
					wr     = 1'b1;
					wr_val = addr;
				end
				pipe_pkg::OP_LW: begin
					wr     = 1'b1;
					wr_val = mem[addr[5:2]];
				end
				pipe_pkg::OP_SW:  mem[addr[5:2]] = b;
				pipe_pkg::OP_BEQ: if (a == b) pc = pc + {imm[29:0], 2'b00};
				default: ;
			endcase
			if (wr && wr_reg != 5'd0) begin	// r0 writes dropped
				regs[wr_reg] = wr_val;
				exp_reg.push_back(wr_reg);
				exp_data.push_back(wr_val);
			end
			steps++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Run and monitor
	////////////////////////////////////////////////////////////
	// One cycle with outputs read on the falling edge
	task automatic sample_cycle();
		int n;
		@(negedge i_clk);
		n = got_reg.size();
		if (o_stall)
			stall_cycles++;
		if (o_imem_addr != addr_seq[$])
			addr_seq.push_back(o_imem_addr);
		if (o_wb_en) begin
			if (n >= exp_reg.size()) begin
				$display("%s: writeback r%0d=%h came after the expected list was used up",
					cur_test, o_wb_reg, o_wb_data);
				test_errs++;
			end else if (o_wb_reg != exp_reg[n] || o_wb_data != exp_data[n]) begin
				$display("[ERROR] %s: writeback %0d expected r%0d=%h, actual r%0d=%h",
					cur_test, n, exp_reg[n], exp_data[n], o_wb_reg, o_wb_data);
				test_errs++;
			end
			got_reg.push_back(o_wb_reg);
			got_data.push_back(o_wb_data);
		end
	endtask

	task automatic run_program();
		int guard;
		got_reg.delete();
		got_data.delete();
		addr_seq.delete();
		stall_cycles = 0;
		run_model();
		apply_reset();
		addr_seq.push_back(o_imem_addr);
		guard = 0;
		while (o_imem_addr < 32'(prog_len * 4) && guard < 1000) begin
			sample_cycle();
			guard++;
		end
		if (guard >= 1000) begin
			$display("%s: fetch never reached the end of the program", cur_test);
			test_errs++;
		end
		repeat (8) sample_cycle();	// Pipeline depth plus a stall
		if (got_reg.size() != exp_reg.size()) begin
			$display("[ERROR] %s: writeback count expected %0d, actual %0d",
				cur_test, exp_reg.size(), got_reg.size());
			test_errs++;
		end
	endtask

	function automatic logic [31:0] addr_after(input logic [31:0] from, input int n);
		for (int i = 0; i < addr_seq.size(); i++)
			if (addr_seq[i] == from && i + n < addr_seq.size())
				return addr_seq[i + n];
		return 32'hffff_ffff;	// Address never fetched
	endfunction

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	initial begin
		i_clk        = 1'b0;
		i_rst_n      = 1'b0;
		seed         = 32'hafb5;
		prog_len     = 0;
		total_errs   = 0;
		tests_run    = 0;
		tests_failed = 0;

		begin_test("reset");
		apply_reset();
		if (o_wb_en !== 1'b0) begin
			$display("[ERROR] reset: o_wb_en expected 0, actual %b", o_wb_en);
			test_errs++;
		end
		if (o_stall !== 1'b0) begin
			$display("[ERROR] reset: o_stall expected 0, actual %b", o_stall);
			test_errs++;
		end
		if (o_imem_addr !== 32'd0) begin
			$display("[ERROR] reset: o_imem_addr expected 0, actual %h", o_imem_addr);
			test_errs++;
		end
		end_test();

		// Back-to-back dependents hit both forwarding paths
		begin_test("arith");
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd1, 5'd0, 16'hfffd));
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd2, 5'd1, 16'd10));
		add_word(r_type(pipe_pkg::FN_ADD, 5'd3, 5'd1, 5'd2));
		add_word(r_type(pipe_pkg::FN_SUB, 5'd4, 5'd3, 5'd2));
		add_word(r_type(pipe_pkg::FN_AND, 5'd5, 5'd4, 5'd3));
		add_word(r_type(pipe_pkg::FN_OR, 5'd6, 5'd5, 5'd1));
		add_word(r_type(pipe_pkg::FN_SLT, 5'd7, 5'd6, 5'd3));	// Negative operand
		run_program();
		end_test();

		begin_test("load_use");
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0055));
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd2, 5'd0, 16'd3));
		add_word(i_type(pipe_pkg::OP_SW, 5'd1, 5'd0, 16'd8));
		add_word(i_type(pipe_pkg::OP_LW, 5'd3, 5'd0, 16'd8));
		add_word(r_type(pipe_pkg::FN_ADD, 5'd4, 5'd3, 5'd2));	// Uses load next cycle
		run_program();
		if (stall_cycles != 1) begin
			$display("[ERROR] load_use: stall cycles expected 1, actual %0d", stall_cycles);
			test_errs++;
		end
		if (got_reg.size() != 4 || got_reg[3] != 5'd4) begin
			$display("load_use: no writeback of the dependent add was seen");
			test_errs++;
		end else if (got_data[3] != 32'h55 + 32'd3) begin
			$display("[ERROR] load_use: add result expected %h, actual %h",
				32'h55 + 32'd3, got_data[3]);
			test_errs++;
		end
		end_test();

		// Taken beq at 8 skips to 24 and untaken beq at 28 falls through
		begin_test("branch");
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd1, 5'd0, 16'd9));
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd2, 5'd0, 16'd9));
		add_word(i_type(pipe_pkg::OP_BEQ, 5'd2, 5'd1, 16'd3));
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd3, 5'd0, 16'd1));	// Shadow
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd4, 5'd0, 16'd2));	// Shadow
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd3, 5'd0, 16'd5));	// Skipped
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd5, 5'd0, 16'd3));
		add_word(i_type(pipe_pkg::OP_BEQ, 5'd5, 5'd1, 16'd3));	// Target 44 if taken
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd6, 5'd0, 16'd4));
		add_word(i_type(pipe_pkg::OP_ADDI, 5'd7, 5'd0, 16'd6));
		run_program();
		for (int i = 0; i < got_reg.size(); i++) begin
			if (got_reg[i] == 5'd3 || got_reg[i] == 5'd4) begin
				$display("branch: a discarded instruction wrote r%0d", got_reg[i]);
				test_errs++;
			end
		end
		if (addr_after(32'd8, 3) != 32'd24) begin
			$display("[ERROR] branch: fetch after taken beq expected %h, actual %h",
				32'd24, addr_after(32'd8, 3));
			test_errs++;
		end
		if (addr_after(32'd28, 3) != 32'd40) begin
			$display("[ERROR] branch: fetch after untaken beq expected %h, actual %h",
				32'd40, addr_after(32'd28, 3));
			test_errs++;
		end
		end_test();

		begin_test("random");
		for (int i = 0; i < 48; i++) begin
			logic [4:0]  rd;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
			rd  = 5'(rand_below(7) + 1);
			rs  = 5'(rand_below(7) + 1);
			rt  = 5'(rand_below(7) + 1);
			imm = 16'($random(seed));
			case (rand_below(9))
				0: add_word(r_type(pipe_pkg::FN_ADD, rd, rs, rt));
				1: add_word(r_type(pipe_pkg::FN_SUB, rd, rs, rt));
				2: add_word(r_type(pipe_pkg::FN_AND, rd, rs, rt));
				3: add_word(r_type(pipe_pkg::FN_OR, rd, rs, rt));
				4: add_word(r_type(pipe_pkg::FN_SLT, rd, rs, rt));
				5: add_word(i_type(pipe_pkg::OP_ADDI, rt, rs, imm));
				6: add_word(i_type(pipe_pkg::OP_LW, rt, 5'd0, 16'(rand_below(16) * 4)));
				7: add_word(i_type(pipe_pkg::OP_SW, rt, 5'd0, 16'(rand_below(16) * 4)));
				default: add_word(i_type(pipe_pkg::OP_BEQ, rt, rs, 16'(rand_below(4) + 1)));
			endcase
		end
		run_program();
		end_test();

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
		if (total_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
